// File: all.f
+incdir+test
src/core_pkg.sv
src/lifo_stack.sv
src/fetch_unit.sv
src/op_decoder.sv
src/execute_unit.sv
src/core_top.sv
test/core_tb.sv

// File: src/core_pkg.sv
// ----------------------------------------------------------
// Core package
// Widths, stack depths, opcode values and shared structs
// ----------------------------------------------------------

package core_pkg;

	// ----------------------------------------------------------
	// Widths and depths
	// ----------------------------------------------------------

	localparam int data_w    = 32;
	localparam int opcode_w  = 7;
	localparam int operand_w = 9;
	localparam int iaddr_w   = 9;
	localparam int daddr_w   = 9;
	localparam int ioaddr_w  = 3;
	localparam int shamt_w   = $clog2(data_w);

	// Return stack and data stack entries
	localparam int ret_depth  = 10;
	localparam int data_depth = 10;

	typedef logic [data_w-1:0]   data_t;
	typedef logic [iaddr_w-1:0]  iaddr_t;
	typedef logic [daddr_w-1:0]  daddr_t;
	typedef logic [ioaddr_w-1:0] ioaddr_t;

	// Instruction word, opcode in the upper bits
	typedef struct packed {
		logic [opcode_w-1:0]  opcode;
		logic [operand_w-1:0] operand;
	} instr_t;

	// ----------------------------------------------------------
	// Opcodes
	// ----------------------------------------------------------

	localparam logic [opcode_w-1:0] op_nop = 'd0;
	localparam logic [opcode_w-1:0] op_lod = 'd1;
	localparam logic [opcode_w-1:0] op_sto = 'd2;
	localparam logic [opcode_w-1:0] op_psh = 'd3;
	localparam logic [opcode_w-1:0] op_pop = 'd4;
	localparam logic [opcode_w-1:0] op_inn = 'd5;
	localparam logic [opcode_w-1:0] op_out = 'd6;
	localparam logic [opcode_w-1:0] op_add = 'd7;
	localparam logic [opcode_w-1:0] op_and = 'd8;
	localparam logic [opcode_w-1:0] op_orr = 'd9;
	localparam logic [opcode_w-1:0] op_xor = 'd10;
	localparam logic [opcode_w-1:0] op_shl = 'd11;
	localparam logic [opcode_w-1:0] op_shr = 'd12;
	// Control flow, handled in fetch
	localparam logic [opcode_w-1:0] op_jmp = 'd13;
	localparam logic [opcode_w-1:0] op_jiz = 'd14;
	localparam logic [opcode_w-1:0] op_cal = 'd15;
	localparam logic [opcode_w-1:0] op_ret = 'd16;
	// Compares yield 1 or 0
	localparam logic [opcode_w-1:0] op_les = 'd17;
	localparam logic [opcode_w-1:0] op_equ = 'd18;

	// ----------------------------------------------------------
	// Execute controls and buses
	// ----------------------------------------------------------

	typedef enum logic [3:0] {
		alu_pass_in1,
		alu_pass_in2,
		alu_add,
		alu_and,
		alu_or,
		alu_xor,
		alu_shl,
		alu_shr,
		alu_les,
		alu_equ
	} alu_op_t;

	typedef enum logic {
		in1_mem,
		in1_stack
	} in1_sel_t;

	typedef struct packed {
		alu_op_t  alu_op;
		in1_sel_t in1_sel;
		logic     acc_we;
		logic     push;
		logic     pop;
		logic     mem_wr;
		logic     out_en;
	} exec_ctrl_t;

	typedef struct packed {
		logic   wr;
		daddr_t addr_rd;
		daddr_t addr_wr;
		data_t  data_wr;
	} dmem_bus_t;

	typedef struct packed {
		logic    req_in;
		ioaddr_t addr_in;
		logic    out_en;
		ioaddr_t addr_out;
		data_t   data_out;
	} io_bus_t;

endpackage

// File: src/core_top.sv
// ----------------------------------------------------------
// Core top
// Fetch, decoder, data stack and execute unit
// ----------------------------------------------------------

module core_top (
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::instr_t    instr,
	output core_pkg::iaddr_t    instr_addr,
	output core_pkg::dmem_bus_t dmem,
	input  core_pkg::data_t     mem_data_rd,
	output core_pkg::io_bus_t   io,
	input  core_pkg::data_t     io_in
);

	// Execute to fetch
	logic result_zero;

	// Decoder outputs
	core_pkg::exec_ctrl_t ctrl;
	core_pkg::daddr_t     addr_rd;
	core_pkg::daddr_t     addr_wr;
	logic                 req_in;
	core_pkg::ioaddr_t    addr_in;
	logic                 out_en;
	core_pkg::ioaddr_t    addr_out;

	// Execute side
	core_pkg::data_t stack_top;
	core_pkg::data_t acc;

	// ----------------------------------------------------------
	// Decode stage
	// ----------------------------------------------------------

	fetch_unit u_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.result_zero (result_zero),
		.instr_addr  (instr_addr)
	);

	op_decoder u_op_decoder (
		.clk      (clk),
		.rst      (rst),
		.instr    (instr),
		.ctrl     (ctrl),
		.addr_rd  (addr_rd),
		.addr_wr  (addr_wr),
		.req_in   (req_in),
		.addr_in  (addr_in),
		.out_en   (out_en),
		.addr_out (addr_out)
	);

	// ----------------------------------------------------------
	// Execute stage
	// ----------------------------------------------------------

	// Data stack, PSH saves acc
	lifo_stack #(
		.entry_t (core_pkg::data_t),
		.depth   (core_pkg::data_depth)
	) u_data_stack (
		.clk  (clk),
		.rst  (rst),
		.push (ctrl.push),
		.pop  (ctrl.pop),
		.din  (acc),
		.top  (stack_top)
	);

	execute_unit u_execute_unit (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ctrl),
		.mem_data_rd (mem_data_rd),
		.stack_top   (stack_top),
		.io_in       (io_in),
		.acc         (acc),
		.result_zero (result_zero)
	);

	// Bus packing
	// Stores and outputs carry the accumulator
	assign dmem = '{wr: ctrl.mem_wr, addr_rd: addr_rd, addr_wr: addr_wr, data_wr: acc};
	assign io   = '{req_in: req_in, addr_in: addr_in, out_en: out_en,
	                addr_out: addr_out, data_out: acc};

endmodule

// File: src/execute_unit.sv
// ----------------------------------------------------------
// Execute unit
// Operand select, ALU, accumulator and zero flag
// ----------------------------------------------------------

module execute_unit (
	input  logic                 clk,
	input  logic                 rst,
	input  core_pkg::exec_ctrl_t ctrl,
	input  core_pkg::data_t      mem_data_rd,
	input  core_pkg::data_t      stack_top,
	input  core_pkg::data_t      io_in,
	output core_pkg::data_t      acc,
	output logic                 result_zero
);

	core_pkg::data_t in1;
	core_pkg::data_t in2;
	core_pkg::data_t alu_out;
	// Value the accumulator holds after this edge
	core_pkg::data_t acc_next;

	logic [core_pkg::shamt_w-1:0] shamt;

	// ----------------------------------------------------------
	// Operand select
	// ----------------------------------------------------------

	assign in1 = (ctrl.in1_sel == core_pkg::in1_stack) ? stack_top : mem_data_rd;

	// Only INN passes in2, so port data rides there
	assign in2 = (ctrl.alu_op == core_pkg::alu_pass_in2) ? io_in : acc;

	// Shift amount from memory operand
	assign shamt = in1[core_pkg::shamt_w-1:0];

	// ----------------------------------------------------------
	// ALU
	// ----------------------------------------------------------

	always_comb begin
		alu_out = '0;
		case (ctrl.alu_op)
			core_pkg::alu_pass_in1: alu_out = in1;
			core_pkg::alu_pass_in2: alu_out = in2;
			core_pkg::alu_add:      alu_out = in2 + in1;
			core_pkg::alu_and:      alu_out = in2 & in1;
			core_pkg::alu_or:       alu_out = in2 | in1;
			core_pkg::alu_xor:      alu_out = in2 ^ in1;
			core_pkg::alu_shl:      alu_out = in2 << shamt;
			// Logical shift, zeros in from the top
			core_pkg::alu_shr:      alu_out = in2 >> shamt;
			core_pkg::alu_les:      alu_out[0] = ($signed(in2) < $signed(in1));
			core_pkg::alu_equ:      alu_out[0] = (in2 == in1);
			default:                alu_out = in1;
		endcase
	end

	// ----------------------------------------------------------
	// Accumulator
	// ----------------------------------------------------------

	assign acc_next = ctrl.acc_we ? alu_out : acc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

	// JIZ in decode sees acc as left by the instruction now executing
	assign result_zero = (acc_next == '0);

endmodule

// File: src/fetch_unit.sv
// ----------------------------------------------------------
// Fetch unit
// Program counter, jump and call/return, return stack
// ----------------------------------------------------------

module fetch_unit (
	input  logic             clk,
	input  logic             rst,
	input  core_pkg::instr_t instr,
	input  logic             result_zero,
	output core_pkg::iaddr_t instr_addr
);

	// Address after the instruction in decode
	core_pkg::iaddr_t pc;
	// Jump target from the operand field
	core_pkg::iaddr_t target;
	core_pkg::iaddr_t ret_top;

	logic is_cal;
	logic is_ret;
	logic take;

	// ----------------------------------------------------------
	// Branch decisions
	// ----------------------------------------------------------

	assign target = instr.operand[core_pkg::iaddr_w-1:0];
	assign is_cal = (instr.opcode == core_pkg::op_cal);
	assign is_ret = (instr.opcode == core_pkg::op_ret);

	always_comb begin
		take = 1'b0;
		case (instr.opcode)
			core_pkg::op_jmp: take = 1'b1;
			// Zero flag is the accumulator value about to be written
			core_pkg::op_jiz: take = result_zero;
			core_pkg::op_cal: take = 1'b1;
			default:          take = 1'b0;
		endcase
	end

	// Return beats jump, jump beats sequential
	assign instr_addr = is_ret ? ret_top : (take ? target : pc);

	// ----------------------------------------------------------
	// Program counter
	// ----------------------------------------------------------

	// No delay slot, next fetch follows the chosen address
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= instr_addr + 1'b1;
		end
	end

	// Return stack
	// CAL saves the address after itself, RET restores it
	lifo_stack #(
		.entry_t (core_pkg::iaddr_t),
		.depth   (core_pkg::ret_depth)
	) u_ret_stack (
		.clk  (clk),
		.rst  (rst),
		.push (is_cal),
		.pop  (is_ret),
		.din  (pc),
		.top  (ret_top)
	);

endmodule

// File: src/lifo_stack.sv
// ----------------------------------------------------------
// LIFO stack
// Pointer based stack, entry type and depth set per instance
// ----------------------------------------------------------

module lifo_stack #(
	parameter type entry_t = logic [7:0],
	parameter int  depth   = 8
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   push,
	input  logic   pop,
	input  entry_t din,
	output entry_t top
);

	// Storage, no reset on entries
	entry_t mem [depth];

	// Next free slot
	logic [$clog2(depth)-1:0] ptr;

	// ----------------------------------------------------------
	// Pointer
	// ----------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	// Write at the free slot
	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr] <= din;
		end
	end

	// Top is the last written entry
	assign top = mem[ptr - 1'b1];

endmodule

// File: src/op_decoder.sv
// ----------------------------------------------------------
// Instruction decoder
// Opcode to execute controls, memory addresses, I/O strobes
// ----------------------------------------------------------

module op_decoder (
	input  logic                 clk,
	input  logic                 rst,
	input  core_pkg::instr_t     instr,
	output core_pkg::exec_ctrl_t ctrl,
	output core_pkg::daddr_t     addr_rd,
	output core_pkg::daddr_t     addr_wr,
	output logic                 req_in,
	output core_pkg::ioaddr_t    addr_in,
	output logic                 out_en,
	output core_pkg::ioaddr_t    addr_out
);

	// Decoded controls for the instruction in decode
	core_pkg::exec_ctrl_t ctrl_d;

	// ----------------------------------------------------------
	// Decode stage
	// ----------------------------------------------------------

	// Memory and port read addresses go out now, data returns next cycle
	assign addr_rd = instr.operand[core_pkg::daddr_w-1:0];
	assign addr_in = instr.operand[core_pkg::ioaddr_w-1:0];
	assign req_in  = (instr.opcode == core_pkg::op_inn);

	always_comb begin
		// Default does nothing to acc, stacks or devices
		ctrl_d         = '0;
		ctrl_d.alu_op  = core_pkg::alu_pass_in1;
		ctrl_d.in1_sel = core_pkg::in1_mem;
		case (instr.opcode)
			core_pkg::op_lod: begin
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_sto: begin
				ctrl_d.mem_wr = 1'b1;
			end
			core_pkg::op_psh: begin
				ctrl_d.push = 1'b1;
			end
			core_pkg::op_pop: begin
				ctrl_d.in1_sel = core_pkg::in1_stack;
				ctrl_d.acc_we  = 1'b1;
				ctrl_d.pop     = 1'b1;
			end
			// Port value arrives as in2
			core_pkg::op_inn: begin
				ctrl_d.alu_op = core_pkg::alu_pass_in2;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_out: begin
				ctrl_d.out_en = 1'b1;
			end
			// Two operand ops, acc against memory
			core_pkg::op_add: begin
				ctrl_d.alu_op = core_pkg::alu_add;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_and: begin
				ctrl_d.alu_op = core_pkg::alu_and;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_orr: begin
				ctrl_d.alu_op = core_pkg::alu_or;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_xor: begin
				ctrl_d.alu_op = core_pkg::alu_xor;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_shl: begin
				ctrl_d.alu_op = core_pkg::alu_shl;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_shr: begin
				ctrl_d.alu_op = core_pkg::alu_shr;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_les: begin
				ctrl_d.alu_op = core_pkg::alu_les;
				ctrl_d.acc_we = 1'b1;
			end
			core_pkg::op_equ: begin
				ctrl_d.alu_op = core_pkg::alu_equ;
				ctrl_d.acc_we = 1'b1;
			end
			// Branches and unknown opcodes stay NOP here
			default: ;
		endcase
	end

	// ----------------------------------------------------------
	// Execute stage registers
	// ----------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl <= '0;
		end else begin
			ctrl <= ctrl_d;
		end
	end

	// Write address and output port follow their instruction
	always_ff @(posedge clk) begin
		addr_wr  <= instr.operand[core_pkg::daddr_w-1:0];
		addr_out <= instr.operand[core_pkg::ioaddr_w-1:0];
	end

	assign out_en = ctrl.out_en;

endmodule

// File: test/core_ref_model.svh
// ----------------------------------------------------------
// Core reference model
// Instruction-set model and the test program images
// ----------------------------------------------------------

// One instruction into the program image
function automatic void place(input core_pkg::iaddr_t addr, input logic [6:0] op,
	input logic [8:0] arg);
	prog_mem[addr] = '{opcode: op, operand: arg};
endfunction

// ----------------------------------------------------------
// Program images
// ----------------------------------------------------------

task automatic load_program(input int sel);
	for (int i = 0; i < mem_words; i++) begin
		prog_mem[i] = '0;
	end
	case (sel)
		// ALU ops on random memory words, each result sent out
		0: begin
			place(0, core_pkg::op_lod, 10);
			place(1, core_pkg::op_out, 0);
			place(2, core_pkg::op_add, 11);
			place(3, core_pkg::op_out, 1);
			place(4, core_pkg::op_and, 12);
			place(5, core_pkg::op_out, 2);
			place(6, core_pkg::op_orr, 13);
			place(7, core_pkg::op_out, 3);
			place(8, core_pkg::op_xor, 14);
			place(9, core_pkg::op_out, 4);
			place(10, core_pkg::op_shl, 15);
			place(11, core_pkg::op_out, 5);
			place(12, core_pkg::op_shr, 16);
			place(13, core_pkg::op_out, 6);
			place(14, core_pkg::op_les, 17);
			place(15, core_pkg::op_out, 7);
			// Equal to itself, so 1
			place(16, core_pkg::op_lod, 18);
			place(17, core_pkg::op_equ, 18);
			place(18, core_pkg::op_out, 0);
			place(19, core_pkg::op_jmp, 19);
		end
		// Three pushes, pops come back reversed
		1: begin
			place(0, core_pkg::op_lod, 30);
			place(1, core_pkg::op_psh, 0);
			place(2, core_pkg::op_lod, 31);
			place(3, core_pkg::op_psh, 0);
			place(4, core_pkg::op_lod, 32);
			place(5, core_pkg::op_psh, 0);
			place(6, core_pkg::op_pop, 0);
			place(7, core_pkg::op_out, 0);
			place(8, core_pkg::op_pop, 0);
			place(9, core_pkg::op_out, 1);
			place(10, core_pkg::op_pop, 0);
			place(11, core_pkg::op_out, 2);
			place(12, core_pkg::op_jmp, 12);
		end
		// JIZ not taken then taken, nested CAL and RET
		2: begin
			place(0, core_pkg::op_lod, 40);
			place(1, core_pkg::op_out, 0);
			place(2, core_pkg::op_jiz, 5);
			place(3, core_pkg::op_out, 1);
			place(4, core_pkg::op_jmp, 6);
			place(5, core_pkg::op_out, 2);
			place(6, core_pkg::op_xor, 40);
			place(7, core_pkg::op_jiz, 9);
			place(8, core_pkg::op_out, 3);
			place(9, core_pkg::op_cal, 20);
			place(10, core_pkg::op_out, 4);
			place(11, core_pkg::op_jmp, 11);
			place(20, core_pkg::op_lod, 41);
			place(21, core_pkg::op_cal, 30);
			place(22, core_pkg::op_out, 5);
			place(23, core_pkg::op_ret, 0);
			place(30, core_pkg::op_add, 42);
			place(31, core_pkg::op_out, 6);
			place(32, core_pkg::op_ret, 0);
		end
		// Port reads, stores and reloads, one unknown opcode
		default: begin
			place(0, core_pkg::op_inn, 3);
			place(1, core_pkg::op_out, 0);
			place(2, core_pkg::op_sto, 50);
			place(3, core_pkg::op_inn, 6);
			place(4, core_pkg::op_sto, 51);
			place(5, core_pkg::op_add, 50);
			place(6, core_pkg::op_out, 1);
			place(7, core_pkg::op_lod, 51);
			place(8, core_pkg::op_sto, 52);
			place(9, 7'd100, 0);
			place(10, core_pkg::op_lod, 52);
			place(11, core_pkg::op_out, 2);
			place(12, core_pkg::op_jmp, 12);
		end
	endcase
endtask

// ----------------------------------------------------------
// Instruction-set model
// ----------------------------------------------------------

// Fills the expected queues, 1 once a self-jump is reached
function automatic bit run_model();
	core_pkg::data_t     mem [mem_words];
	core_pkg::data_t     stk [$];
	core_pkg::iaddr_t    rets [$];
	core_pkg::data_t     acc;
	core_pkg::data_t     opnd;
	core_pkg::iaddr_t    pc;
	core_pkg::iaddr_t    next_pc;
	core_pkg::instr_t    ins;
	core_pkg::dmem_bus_t st;
	core_pkg::io_bus_t   ev;
	bit                  halted;
	for (int i = 0; i < mem_words; i++) begin
		mem[i] = dev_mem[i];
	end
	acc    = '0;
	pc     = '0;
	halted = 1'b0;
	for (int step = 0; step < step_bound && !halted; step++) begin
		ins     = prog_mem[pc];
		opnd    = mem[ins.operand];
		next_pc = pc + 1'b1;
		st      = '0;
		ev      = '0;
		case (ins.opcode)
			core_pkg::op_lod: acc = opnd;
			core_pkg::op_sto: begin
				st.wr      = 1'b1;
				st.addr_wr = ins.operand;
				st.data_wr = acc;
				exp_dmem.push_back(st);
				mem[ins.operand] = acc;
			end
			core_pkg::op_psh: stk.push_back(acc);
			core_pkg::op_pop: acc = stk.pop_back();
			core_pkg::op_inn: acc = port_val[ins.operand[core_pkg::ioaddr_w-1:0]];
			core_pkg::op_out: begin
				ev.out_en   = 1'b1;
				ev.addr_out = ins.operand[core_pkg::ioaddr_w-1:0];
				ev.data_out = acc;
				exp_io.push_back(ev);
			end
			core_pkg::op_add: acc = acc + opnd;
			core_pkg::op_and: acc = acc & opnd;
			core_pkg::op_orr: acc = acc | opnd;
			core_pkg::op_xor: acc = acc ^ opnd;
			// Amount is the low five bits of the memory word
			core_pkg::op_shl: acc = acc << opnd[4:0];
			core_pkg::op_shr: acc = acc >> opnd[4:0];
			core_pkg::op_les: acc = ($signed(acc) < $signed(opnd)) ? 32'd1 : 32'd0;
			core_pkg::op_equ: acc = (acc == opnd) ? 32'd1 : 32'd0;
			core_pkg::op_jmp: begin
				halted  = (ins.operand == pc);
				next_pc = ins.operand;
			end
			core_pkg::op_jiz: begin
				if (acc == '0) begin
					next_pc = ins.operand;
				end
			end
			core_pkg::op_cal: begin
				rets.push_back(pc + 1'b1);
				next_pc = ins.operand;
			end
			core_pkg::op_ret: next_pc = rets.pop_back();
			default: ;
		endcase
		pc = next_pc;
	end
	return halted;
endfunction

// File: test/core_tb.sv
// ----------------------------------------------------------
// Core testbench
// Device models, reference compare and watchdog
// ----------------------------------------------------------

module core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period   = 40;
	localparam int reset_cycles = 16;
	localparam int step_bound   = 200;
	localparam int num_progs    = 4;
	localparam int mem_words    = 512;
	localparam int num_ports    = 8;

	logic                clk;
	logic                rst;
	core_pkg::instr_t    instr;
	core_pkg::iaddr_t    instr_addr;
	core_pkg::dmem_bus_t dmem;
	core_pkg::data_t     mem_data_rd;
	core_pkg::io_bus_t   io;
	core_pkg::data_t     io_in;

	// Device contents
	core_pkg::instr_t prog_mem [mem_words];
	core_pkg::data_t  dev_mem  [mem_words];
	core_pkg::data_t  port_val [num_ports];

	// Expected events in program order
	core_pkg::dmem_bus_t exp_dmem [$];
	core_pkg::io_bus_t   exp_io   [$];

	// Address of the word now at instr
	core_pkg::iaddr_t cur_addr;
	integer           seed;
	logic             checking;

	`include "core_ref_model.svh"

	core_top u_core_top (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.dmem        (dmem),
		.mem_data_rd (mem_data_rd),
		.io          (io),
		.io_in       (io_in)
	);

	always #(clk_period / 2) clk = ~clk;

	// ----------------------------------------------------------
	// Devices, one cycle read latency
	// ----------------------------------------------------------

	always @(posedge clk) begin
		if (rst) begin
			instr    <= '{opcode: core_pkg::op_nop, operand: '0};
			cur_addr <= '0;
		end else begin
			instr    <= prog_mem[instr_addr];
			cur_addr <= instr_addr;
		end
		mem_data_rd <= dev_mem[dmem.addr_rd];
		// Ports only answer a read request
		io_in       <= io.req_in ? port_val[io.addr_in] : 'x;
		if (dmem.wr) begin
			dev_mem[dmem.addr_wr] <= dmem.data_wr;
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input core_pkg::data_t exp,
		input core_pkg::data_t got);
		stop_on_failure($sformatf("ERROR t=%0t %s expected %h got %h",
			$time, name, exp, got));
	endtask

	task automatic check_dmem(input core_pkg::dmem_bus_t got, input core_pkg::dmem_bus_t exp);
		if (got.addr_wr !== exp.addr_wr) begin
			report_mismatch("dmem.addr_wr", exp.addr_wr, got.addr_wr);
		end
		if (got.data_wr !== exp.data_wr) begin
			report_mismatch("dmem.data_wr", exp.data_wr, got.data_wr);
		end
	endtask

	task automatic check_io(input core_pkg::io_bus_t got, input core_pkg::io_bus_t exp);
		if (got.addr_out !== exp.addr_out) begin
			report_mismatch("io.addr_out", exp.addr_out, got.addr_out);
		end
		if (got.data_out !== exp.data_out) begin
			report_mismatch("io.data_out", exp.data_out, got.data_out);
		end
	endtask

	task automatic check_addr(input string name, input core_pkg::iaddr_t got,
		input core_pkg::iaddr_t exp);
		if (got !== exp) begin
			report_mismatch(name, exp, got);
		end
	endtask

	task automatic check_strobe(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_mismatch(name, exp, got);
		end
	endtask

	// Compare process, one expected entry per strobe
	always @(negedge clk) begin
		if (checking && dmem.wr) begin
			if (exp_dmem.size() == 0) begin
				stop_on_failure("A store appeared that the program does not make");
			end else begin
				check_dmem(dmem, exp_dmem.pop_front());
			end
		end
		if (checking && io.out_en) begin
			if (exp_io.size() == 0) begin
				stop_on_failure("An output appeared that the program does not make");
			end else begin
				check_io(io, exp_io.pop_front());
			end
		end
	end

	// ----------------------------------------------------------
	// Program runs
	// ----------------------------------------------------------

	task automatic run_program(input int sel);
		int i;
		@(posedge clk);
		checking = 1'b0;
		rst      <= 1'b1;
		@(negedge clk);
		for (i = 0; i < mem_words; i++) begin
			dev_mem[i] = $random(seed);
		end
		for (i = 0; i < num_ports; i++) begin
			port_val[i] = $random(seed);
		end
		load_program(sel);
		exp_dmem.delete();
		exp_io.delete();
		if (!run_model()) begin
			stop_on_failure("The reference model found no self-jump in the program");
		end
		// First reset cycle may still show the previous fetch
		for (i = 1; i < reset_cycles; i++) begin
			@(negedge clk);
			check_addr("instr_addr", instr_addr, '0);
			check_strobe("dmem.wr", dmem.wr, 1'b0);
			check_strobe("io.req_in", io.req_in, 1'b0);
			check_strobe("io.out_en", io.out_en, 1'b0);
		end
		@(posedge clk);
		rst      <= 1'b0;
		checking = 1'b1;
		// Release edge itself still resets
		@(negedge clk);
		check_addr("instr_addr", instr_addr, '0);
		check_strobe("dmem.wr", dmem.wr, 1'b0);
		check_strobe("io.req_in", io.req_in, 1'b0);
		check_strobe("io.out_en", io.out_en, 1'b0);
		if (sel == 0) begin
			for (i = 1; i <= 8; i++) begin
				@(negedge clk);
				check_addr("instr_addr", instr_addr, core_pkg::iaddr_t'(i));
			end
		end
		while (!(instr.opcode == core_pkg::op_jmp && instr.operand == cur_addr)) begin
			@(negedge clk);
		end
		// Let the last instruction drain
		repeat (3) @(posedge clk);
		if (exp_dmem.size() != 0 || exp_io.size() != 0) begin
			stop_on_failure($sformatf("Program %0d halted with %0d stores and %0d outputs missing",
				sel, exp_dmem.size(), exp_io.size()));
		end
	endtask

	initial begin
		seed        = 32'h5bb4b93a;
		clk         = 1'b0;
		rst         = 1'b1;
		instr       = '0;
		mem_data_rd = '0;
		io_in       = '0;
		cur_addr    = '0;
		checking    = 1'b0;
		for (int p = 0; p < num_progs; p++) begin
			run_program(p);
		end
		$display("** PASS **");
		$finish;
	end

	// Watchdog
	initial begin
		#(num_progs * step_bound * 2 * clk_period);
		stop_on_failure("Timeout, the run did not finish");
	end

endmodule
